/* compile.f */
verilog/board_pkg.sv
verilog/byte_ram.sv
verilog/mem_lanes.sv
verilog/io_space.sv
verilog/led_matrix_scan.sv
verilog/board_core.sv
tb/tb_checker.sv
tb/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_top.sv */
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int bus_phase_cycles = 2000;  // directed plus random bus traffic
  localparam int timeout_cycles =
    2 * board_pkg::scan_rows * board_pkg::scan_period + bus_phase_cycles + 5000;

  logic                            sys_clk = 1'b0;
  logic                            rst_n;
  logic [11:0]                     mem_addr;
  logic                            mem_wr;
  logic                            mem_byt;
  logic [15:0]                     wr_data;
  logic [15:0]                     rd_data;
  logic [15:0]                     dbg_insn;
  logic [15:0]                     dbg_stack0;
  logic [15:0]                     dbg_stack1;
  logic [5:0]                      dbg_alu_sel;
  logic [board_pkg::scan_rows-1:0] led_row;
  logic [7:0]                      led_col;
  logic                            lcd_e;
  logic                            lcd_rw;
  logic                            lcd_rs;
  logic [3:0]                      lcd_db;
  logic [7:0]                      gpio;

  logic [7:0]  ref_mem [4096];  // reference memory
  logic        ref_known [4096];
  logic [7:0]  ref_led;
  logic [7:0]  ref_lcd;
  logic [7:0]  ref_gpio;
  logic [31:0] lfsr;
  logic [1:0]  op;
  logic [11:0] addr;
  int          cycle_count = 0;
  int          rows_done;
  int          read_errs;
  int          io_errs;
  int          scan_errs;

  always #2 sys_clk = ~sys_clk;

  board_core u_dut (.*);

  tb_checker u_checker (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic bus_write(input logic [11:0] a, input logic [15:0] d, input logic byt);
    @(negedge sys_clk);
    mem_addr = a;
    mem_wr   = 1'b1;
    mem_byt  = byt;
    wr_data  = d;
  endtask

  task automatic bus_read(input logic [11:0] a);
    @(negedge sys_clk);
    mem_addr = a;
    mem_wr   = 1'b0;
    mem_byt  = 1'b0;
  endtask

  // model follows the write rule, updated on the same edge as the DUT
  always @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      ref_led  <= 8'd0;
      ref_lcd  <= 8'd0;
      ref_gpio <= 8'd0;
      for (int i = 0; i < 4096; i++) ref_known[i] <= 1'b0;
    end else if (mem_wr) begin
      if ((mem_addr & board_pkg::io_window_mask) == board_pkg::io_window_base) begin
        if (mem_addr == board_pkg::io_led_addr) begin
          ref_led <= wr_data[7:0];
          if (!mem_byt) ref_lcd <= wr_data[15:8];
        end
        if (mem_addr == board_pkg::io_lcd_addr) ref_lcd <= wr_data[15:8];
        if (mem_addr == board_pkg::io_gpio_addr) ref_gpio <= wr_data[7:0];
      end else begin
        ref_mem[mem_addr]   <= wr_data[7:0];
        ref_known[mem_addr] <= 1'b1;
        if (!mem_byt) begin
          ref_mem[mem_addr + 12'd1]   <= wr_data[15:8];
          ref_known[mem_addr + 12'd1] <= 1'b1;
        end
      end
    end
  end

  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: only %0d LED rows finished after %0d cycles", rows_done, cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    {mem_addr, mem_wr, mem_byt, wr_data} = '0;
    {dbg_insn, dbg_stack0, dbg_stack1, dbg_alu_sel} = '0;
    lfsr  = 32'h8a0b;
    rst_n = 1'b1;
    #1 rst_n = 1'b0;
    repeat (8) @(negedge sys_clk);
    rst_n = 1'b1;
    for (int i = 0; i < 200; i++) begin  // aligned and unaligned words
      addr = {4'h1, 8'(take_bits(8))};
      bus_write(addr, 16'(take_bits(16)), 1'b0);
      bus_read(addr);
    end
    for (int i = 0; i < 100; i++) begin  // byte writes, neighbour kept
      addr = {4'h1, 8'(take_bits(8))};
      bus_write(addr, 16'(take_bits(16)), 1'b1);
      bus_read(addr);
      bus_read(addr - 12'd1);
    end
    bus_write(12'h07f, 16'(take_bits(16)), 1'b0);  // RAM byte under 0x080
    bus_write(12'h100, 16'(take_bits(16)), 1'b0);  // RAM byte above 0x0ff
    bus_write(board_pkg::io_led_addr, 16'(take_bits(16)), 1'b1);
    bus_read(board_pkg::io_led_addr);
    bus_write(board_pkg::io_led_addr, 16'(take_bits(16)), 1'b0);
    bus_read(board_pkg::io_lcd_addr);
    bus_write(board_pkg::io_lcd_addr, 16'(take_bits(16)), 1'b0);
    bus_read(board_pkg::io_led_addr);
    bus_write(board_pkg::io_gpio_addr, 16'(take_bits(16)), 1'b0);
    bus_read(board_pkg::io_gpio_addr);
    bus_write(12'h0ff, 16'(take_bits(16)), 1'b0);  // would spill into 0x100
    bus_write(12'h0c0, 16'(take_bits(16)), 1'b1);
    for (int k = 'h83; k < 'h100; k++) bus_read(12'(k));
    bus_read(12'h07f);
    bus_read(12'h100);
    for (int i = 0; i < 300; i++) bus_read({4'h1, 8'(take_bits(8))});  // back to back
    for (int i = 0; i < 400; i++) begin
      op   = 2'(take_bits(2));
      addr = {4'h1, 8'(take_bits(8))};
      if (op[1]) bus_read(addr);
      else bus_write(addr, 16'(take_bits(16)), op[0]);
    end
    // scanner runs on while probes and led move
    for (int n = 0; rows_done < 2 * board_pkg::scan_rows; n++) begin
      if (n % 500 == 0) begin
        bus_write(board_pkg::io_led_addr, 16'(take_bits(16)), 1'b1);
        dbg_insn    = 16'(take_bits(16));
        dbg_stack0  = 16'(take_bits(16));
        dbg_stack1  = 16'(take_bits(16));
        dbg_alu_sel = 6'(take_bits(6));
      end else begin
        bus_read({4'h1, 8'(take_bits(8))});
      end
    end
    bus_read(12'h100);
    bus_read(12'h100);
    $display("errors: read %0d, io %0d, scan %0d", read_errs, io_errs, scan_errs);
    if (read_errs + io_errs + scan_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* tb/tb_checker.sv */
module tb_checker (
  input  logic                            sys_clk,
  input  logic                            rst_n,
  input  logic [11:0]                     mem_addr,
  input  logic                            mem_wr,
  input  logic [15:0]                     rd_data,
  input  logic [15:0]                     dbg_insn,
  input  logic [15:0]                     dbg_stack0,
  input  logic [15:0]                     dbg_stack1,
  input  logic [5:0]                      dbg_alu_sel,
  input  logic [board_pkg::scan_rows-1:0] led_row,
  input  logic [7:0]                      led_col,
  input  logic                            lcd_e,
  input  logic                            lcd_rw,
  input  logic                            lcd_rs,
  input  logic [3:0]                      lcd_db,
  input  logic [7:0]                      gpio,
  input  logic [7:0]                      ref_mem [4096],
  input  logic                            ref_known [4096],
  input  logic [7:0]                      ref_led,
  input  logic [7:0]                      ref_lcd,
  input  logic [7:0]                      ref_gpio,
  output int                              rows_done,
  output int                              read_errs,
  output int                              io_errs,
  output int                              scan_errs
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int lit_cycles = board_pkg::scan_period - board_pkg::gap_on - board_pkg::gap_off;

  logic [11:0] prev_addr;  // address whose data shows on rd_data now
  logic        prev_wr;
  logic        prev_valid;
  logic        in_stretch;
  int          cur_row;
  int          last_row;
  int          stretch_len;

  initial begin
    rows_done  = 0;
    read_errs  = 0;
    io_errs    = 0;
    scan_errs  = 0;
    prev_valid = 1'b0;
    in_stretch = 1'b0;
    last_row   = -1;  // first lit row may be any
  end

  function automatic logic in_window(input logic [11:0] a);
    return (a & board_pkg::io_window_mask) == board_pkg::io_window_base;
  endfunction

  // little-endian word from the model, I/O window overrides memory
  function automatic logic [15:0] expected_read(input logic [11:0] a);
    if (!in_window(a)) begin
      return {ref_mem[a + 12'd1], ref_mem[a]};
    end else if ({a[11:1], 1'b0} == board_pkg::io_led_addr) begin
      return {ref_lcd, ref_led};
    end else if ({a[11:1], 1'b0} == board_pkg::io_gpio_addr) begin
      return {8'd0, ref_gpio};
    end
    return 16'd0;
  endfunction

  // bytes never written are left out of the compare
  function automatic logic [15:0] read_mask(input logic [11:0] a);
    if (in_window(a)) begin
      return 16'hffff;
    end
    return {{8{ref_known[a + 12'd1]}}, {8{ref_known[a]}}};
  endfunction

  function automatic logic [7:0] expected_col(input int r);
    case (r)
      0: return dbg_insn[15:8];
      1: return dbg_insn[7:0];
      2: return dbg_stack0[15:8];
      3: return dbg_stack0[7:0];
      4: return dbg_stack1[15:8];
      5: return dbg_stack1[7:0];
      6: return {2'b00, dbg_alu_sel};
      7: return ref_led;
      8: return {board_pkg::seg_table[mem_addr[3:0]], mem_addr[4]};
      default: return 8'h00;
    endcase
  endfunction

  // sampled on the rising edge, before any register moves
  always @(posedge sys_clk) begin : compare
    logic [board_pkg::scan_rows-1:0] lit;
    logic [15:0]                     mask;
    int                              r;
    lit = ~led_row;
    r   = 0;
    if (!rst_n) begin
      prev_valid = 1'b0;
      if (lit != '0 || {lcd_db, lcd_rs, lcd_rw, lcd_e} != 7'd0 || gpio != 8'd0) begin
        $display("mismatch at %0t: reset state led_row %b lcd %h gpio %h", $time,
                 led_row, {lcd_db, lcd_rs, lcd_rw, lcd_e}, gpio);
        io_errs++;
      end
    end else begin
      if (prev_valid && !prev_wr) begin  // read-first RAM, skip reads issued with a write
        mask = read_mask(prev_addr);
        if ((rd_data & mask) !== (expected_read(prev_addr) & mask)) begin
          $display("mismatch at %0t: read of %h gave %h, expected %h", $time, prev_addr,
                   rd_data, expected_read(prev_addr));
          read_errs++;
        end
      end
      prev_valid = 1'b1;
      prev_addr  = mem_addr;
      prev_wr    = mem_wr;
      if ({lcd_db, lcd_rs, lcd_rw, lcd_e} != {ref_lcd[7:4], ref_lcd[2:0]} || gpio != ref_gpio) begin
        $display("mismatch at %0t: lcd pins %h gpio %h, expected lcd %h gpio %h", $time,
                 {lcd_db, lcd_rs, lcd_rw, lcd_e}, gpio, ref_lcd, ref_gpio);
        io_errs++;
      end
      if (lit != '0 && !$onehot(lit)) begin
        $display("more than one LED row is lit at once at %0t", $time);
        scan_errs++;
      end else if (lit != '0) begin
        for (int i = 0; i < board_pkg::scan_rows; i++) begin
          if (lit[i]) r = i;
        end
        if (led_col != expected_col(r)) begin
          $display("mismatch at %0t: row %0d column %h, expected %h", $time, r, led_col,
                   expected_col(r));
          scan_errs++;
        end
        if (!in_stretch) begin  // new row lit
          if (last_row >= 0 && r != (last_row + 1) % board_pkg::scan_rows) begin
            $display("mismatch at %0t: row %0d lit after row %0d", $time, r, last_row);
            scan_errs++;
          end
          in_stretch  = 1'b1;
          cur_row     = r;
          stretch_len = 1;
        end else begin
          if (r != cur_row) begin
            $display("mismatch at %0t: row changed from %0d to %0d without a gap", $time,
                     cur_row, r);
            scan_errs++;
          end
          stretch_len++;
        end
      end else if (in_stretch) begin
        if (stretch_len != lit_cycles) begin
          $display("mismatch at %0t: row %0d lit for %0d cycles, expected %0d", $time,
                   cur_row, stretch_len, lit_cycles);
          scan_errs++;
        end
        in_stretch = 1'b0;
        last_row   = cur_row;
        rows_done++;
      end
    end
  end

endmodule

/* verilog/board_core.sv */
module board_core (
  input  logic                             sys_clk,
  input  logic                             rst_n,
  input  logic [board_pkg::addr_width-1:0] mem_addr,
  input  logic                             mem_wr,
  input  logic                             mem_byt,
  input  logic [15:0]                      wr_data,
  output logic [15:0]                      rd_data,
  input  logic [15:0]                      dbg_insn,
  input  logic [15:0]                      dbg_stack0,
  input  logic [15:0]                      dbg_stack1,
  input  logic [5:0]                       dbg_alu_sel,
  output logic [board_pkg::scan_rows-1:0]  led_row,
  output logic [7:0]                       led_col,
  output logic                             lcd_e,
  output logic                             lcd_rw,
  output logic                             lcd_rs,
  output logic [3:0]                       lcd_db,
  output logic [7:0]                       gpio
);

  logic [15:0] mem_word;  // RAM word, one clock after the address
  logic [7:0]  io_led;

  mem_lanes u_mem_lanes (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .mem_addr (mem_addr),
    .mem_wr   (mem_wr),
    .mem_byt  (mem_byt),
    .wr_data  (wr_data),
    .mem_word (mem_word)
  );

  io_space u_io_space (
    .sys_clk  (sys_clk),
    .rst_n    (rst_n),
    .mem_addr (mem_addr),
    .mem_wr   (mem_wr),
    .mem_byt  (mem_byt),
    .wr_data  (wr_data),
    .mem_word (mem_word),
    .rd_data  (rd_data),
    .io_led   (io_led),
    .lcd_e    (lcd_e),
    .lcd_rw   (lcd_rw),
    .lcd_rs   (lcd_rs),
    .lcd_db   (lcd_db),
    .gpio     (gpio)
  );

  // debug view
  led_matrix_scan u_led_matrix_scan (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .dbg_insn    (dbg_insn),
    .dbg_stack0  (dbg_stack0),
    .dbg_stack1  (dbg_stack1),
    .dbg_alu_sel (dbg_alu_sel),
    .io_led      (io_led),
    .mem_addr    (mem_addr),
    .led_row     (led_row),
    .led_col     (led_col)
  );

endmodule

/* verilog/led_matrix_scan.sv */
module led_matrix_scan (
  input  logic                            sys_clk,
  input  logic                            rst_n,
  input  logic [15:0]                     dbg_insn,
  input  logic [15:0]                     dbg_stack0,
  input  logic [15:0]                     dbg_stack1,
  input  logic [5:0]                      dbg_alu_sel,
  input  logic [7:0]                      io_led,
  input  logic [11:0]                     mem_addr,
  output logic [board_pkg::scan_rows-1:0] led_row,
  output logic [7:0]                      led_col
);

  localparam int tw = board_pkg::scan_timer_width;
  localparam int rw = board_pkg::row_index_width;

  localparam logic [tw-1:0] timer_last = tw'(board_pkg::scan_period - 1);
  localparam logic [tw-1:0] lit_start  = tw'(board_pkg::gap_on);
  localparam logic [tw-1:0] lit_end    = tw'(board_pkg::scan_period - board_pkg::gap_off);
  localparam logic [rw-1:0] row_last   = rw'(board_pkg::scan_rows - 1);

  logic [tw-1:0]                   row_timer;
  logic [rw-1:0]                   row_index;
  logic                            row_lit;
  logic [board_pkg::scan_rows-1:0] row_onehot;
  logic [6:0]                      seg_code;

  // one row per scan_period
  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      row_timer <= '0;
    end else if (row_timer == timer_last) begin
      row_timer <= '0;
    end else begin
      row_timer <= row_timer + 1'b1;
    end
  end

  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      row_index <= '0;
    end else if (row_timer == '0) begin
      if (row_index == row_last) begin
        row_index <= '0;
      end else begin
        row_index <= row_index + 1'b1;
      end
    end
  end

  // dark at both ends of a row so the old column data does not ghost
  assign row_lit = (row_timer >= lit_start) && (row_timer < lit_end);

  assign row_onehot = row_lit ? (board_pkg::scan_rows'(1) << row_index) : '0;
  assign led_row    = ~row_onehot;  // active low

  // 7-segment view of the bus address
  assign seg_code = board_pkg::seg_table[mem_addr[3:0]];

  always_comb begin
    case (row_index)
      4'd0:    led_col = dbg_insn[15:8];
      4'd1:    led_col = dbg_insn[7:0];
      4'd2:    led_col = dbg_stack0[15:8];
      4'd3:    led_col = dbg_stack0[7:0];
      4'd4:    led_col = dbg_stack1[15:8];
      4'd5:    led_col = dbg_stack1[7:0];
      4'd6:    led_col = {2'd0, dbg_alu_sel};
      4'd7:    led_col = io_led;
      4'd8:    led_col = {seg_code, mem_addr[4]};  // addr bit 4 on the dot
      default: led_col = 8'd0;
    endcase
  end

  a_row_in_range : assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    row_index <= row_last
  ) else $error("row_index past last row");

endmodule

/* verilog/io_space.sv */
module io_space (
  input  logic                             sys_clk,
  input  logic                             rst_n,
  input  logic [board_pkg::addr_width-1:0] mem_addr,
  input  logic                             mem_wr,
  input  logic                             mem_byt,
  input  logic [15:0]                      wr_data,
  input  logic [15:0]                      mem_word,
  output logic [15:0]                      rd_data,
  output logic [7:0]                       io_led,
  output logic                             lcd_e,
  output logic                             lcd_rw,
  output logic                             lcd_rs,
  output logic [3:0]                       lcd_db,
  output logic [7:0]                       gpio
);

  logic [7:0]                       lcd;
  logic [board_pkg::addr_width-1:0] mem_addr_d;  // lines up with RAM read data
  logic                             io_hit_d;
  logic                             led_pair_d;  // 0x080..0x081
  logic                             gpio_pair_d; // 0x082..0x083

  // register writes
  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      io_led <= 8'd0;
      lcd    <= 8'd0;
      gpio   <= 8'd0;
    end else if (mem_wr) begin
      case (mem_addr)
        board_pkg::io_led_addr: begin
          if (mem_byt) begin
            io_led <= wr_data[7:0];
          end else begin
            {lcd, io_led} <= wr_data;  // word write also sets lcd
          end
        end
        board_pkg::io_lcd_addr:  lcd  <= wr_data[15:8];
        board_pkg::io_gpio_addr: gpio <= wr_data[7:0];
        default: ;
      endcase
    end
  end

  // LCD pins straight off the register
  assign lcd_e  = lcd[0];
  assign lcd_rw = lcd[1];
  assign lcd_rs = lcd[2];
  assign lcd_db = lcd[7:4];  // bit 3 only reads back

  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      mem_addr_d <= '0;
    end else begin
      mem_addr_d <= mem_addr;
    end
  end

  assign io_hit_d = (mem_addr_d & board_pkg::io_window_mask) == board_pkg::io_window_base;

  // word pairs, ignore bit 0
  assign led_pair_d =
    mem_addr_d[board_pkg::addr_width-1:1] == board_pkg::io_led_addr[board_pkg::addr_width-1:1];
  assign gpio_pair_d =
    mem_addr_d[board_pkg::addr_width-1:1] == board_pkg::io_gpio_addr[board_pkg::addr_width-1:1];

  // read-back mux
  always_comb begin
    if (!io_hit_d) begin
      rd_data = mem_word;
    end else if (led_pair_d) begin
      rd_data = {lcd, io_led};
    end else if (gpio_pair_d) begin
      rd_data = {8'd0, gpio};
    end else begin
      rd_data = 16'd0;  // rest of the window
    end
  end

  a_reg_change_after_wr : assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    !$stable({lcd, gpio}) |-> $past(mem_wr)
  ) else $error("lcd or gpio changed without a write strobe");

endmodule

/* verilog/mem_lanes.sv */
module mem_lanes (
  input  logic                             sys_clk,
  input  logic                             rst_n,
  input  logic [board_pkg::addr_width-1:0] mem_addr,
  input  logic                             mem_wr,
  input  logic                             mem_byt,
  input  logic [15:0]                      wr_data,
  output logic [15:0]                      mem_word
);

  logic [board_pkg::bank_addr_width-1:0] addr_half;
  logic [board_pkg::bank_addr_width-1:0] addr_next;
  logic [board_pkg::bank_addr_width-1:0] even_addr;
  logic [board_pkg::bank_addr_width-1:0] odd_addr;
  logic       odd;
  logic       io_hit;
  logic       even_wr;
  logic       odd_wr;
  logic [7:0] even_wr_byte;
  logic [7:0] odd_wr_byte;
  logic [7:0] even_rd_byte;
  logic [7:0] odd_rd_byte;
  logic       swap_q;  // odd address of the access now returning

  assign odd       = mem_addr[0];
  assign addr_half = mem_addr[board_pkg::addr_width-1:1];
  assign addr_next = addr_half + 1'b1;  // wraps at the top of memory

  assign io_hit = (mem_addr & board_pkg::io_window_mask) == board_pkg::io_window_base;

  // odd access: low byte sits in the odd bank, high byte one row up in the even bank
  assign even_addr = odd ? addr_next : addr_half;
  assign odd_addr  = addr_half;

  assign even_wr_byte = odd ? wr_data[15:8] : wr_data[7:0];
  assign odd_wr_byte  = odd ? wr_data[7:0]  : wr_data[15:8];

  // byte write touches only the bank holding addr
  assign even_wr = mem_wr && !io_hit && (!odd || !mem_byt);
  assign odd_wr  = mem_wr && !io_hit && (odd || !mem_byt);

  byte_ram bank_even (
    .sys_clk (sys_clk),
    .wr      (even_wr),
    .addr    (even_addr),
    .wr_byte (even_wr_byte),
    .rd_byte (even_rd_byte)
  );

  byte_ram bank_odd (
    .sys_clk (sys_clk),
    .wr      (odd_wr),
    .addr    (odd_addr),
    .wr_byte (odd_wr_byte),
    .rd_byte (odd_rd_byte)
  );

  // follows the bank address register by one clock
  always_ff @(posedge sys_clk, negedge rst_n) begin
    if (!rst_n) begin
      swap_q <= 1'b0;
    end else begin
      swap_q <= odd;
    end
  end

  // little-endian word back in order
  assign mem_word = swap_q ? {even_rd_byte, odd_rd_byte} : {odd_rd_byte, even_rd_byte};

  a_byte_one_bank : assert property (
    @(posedge sys_clk) disable iff (!rst_n)
    (mem_wr && mem_byt) |-> $onehot0({even_wr, odd_wr})
  ) else $error("byte write enabled both banks");

endmodule

/* verilog/byte_ram.sv */
module byte_ram (
  input  logic                                  sys_clk,
  input  logic                                  wr,
  input  logic [board_pkg::bank_addr_width-1:0] addr,
  input  logic [7:0]                            wr_byte,
  output logic [7:0]                            rd_byte
);

  localparam int depth = 2 ** board_pkg::bank_addr_width;

  logic [7:0] mem [depth];  // contents undefined until written

  // port A write
  always_ff @(posedge sys_clk) begin
    if (wr) begin
      mem[addr] <= wr_byte;
    end
  end

  // port B read, same address as port A on this board
  // read-first: a write shows up on the next access
  always_ff @(posedge sys_clk) begin
    rd_byte <= mem[addr];
  end

endmodule

/* verilog/board_pkg.sv */
package board_pkg;

  // byte address space, 4 KiB
  localparam int addr_width      = 12;
  localparam int bank_addr_width = addr_width - 1;  // each bank holds every other byte

  // memory-mapped I/O registers
  localparam logic [addr_width-1:0] io_led_addr  = 12'h080;
  localparam logic [addr_width-1:0] io_lcd_addr  = 12'h081;
  localparam logic [addr_width-1:0] io_gpio_addr = 12'h082;

  // 0x080..0x0ff is I/O, memory never sees it
  localparam logic [addr_width-1:0] io_window_mask = 12'hf80;
  localparam logic [addr_width-1:0] io_window_base = 12'h080;

  // LED matrix scan timing, in sys_clk cycles
  localparam int scan_period       = 27000;
  localparam int gap_on            = 100;   // dark lead-in of each row
  localparam int gap_off           = 2000;  // dark tail of each row
  localparam int scan_timer_width  = 15;
  localparam int scan_rows         = 9;
  localparam int row_index_width   = 4;

  // segments a..g in bits 6:0, a on top going clockwise, g is the middle bar
  localparam logic [6:0] seg_table [16] = '{
    7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001,
    7'b0110011, 7'b1011011, 7'b1011111, 7'b1110010,
    7'b1111111, 7'b1111011, 7'b1110111, 7'b0011111,
    7'b1001110, 7'b0111101, 7'b1001111, 7'b1000111
  };

endpackage
